// ==== all.f ====
mips_isa_pkg.sv
pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
mini_mips_core.sv
tb_checker.sv
tb_top.sv

// ==== Bender.yml ====
package:
  name: mini_mips_core

sources:
  - mips_isa_pkg.sv
  - pipe_pkg.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - writeback_stage.sv
  - mini_mips_core.sv
  - target: simulation
    files:
      - tb_checker.sv
      - tb_top.sv

// ==== tb_top.sv ====
`default_nettype none

module tb_top
    import mips_isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'hBFC0_0000
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_MAX  = 64;
    localparam int NUM_TESTS = 5;

    logic        Clk;
    logic        Myreset;
    logic        inst_req;
    word_t       inst_addr;
    word_t       inst_rdata;
    logic        inst_data_ok;
    word_t       trace_pc;
    logic [3:0]  trace_wen;
    reg_num_t    trace_wnum;
    word_t       trace_wdata;
    word_t       prog_mem [PROG_MAX];
    logic [31:0] prog_len;
    logic        start_test;
    logic        end_test;
    logic        test_done;
    int          tests_failed;
    int          errors;
    int          checks;
    int unsigned lcg_state;
    int          delay_left;
    int          cycle_count;
    int          cycle_limit;
    logic        timed_out;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    function automatic reg_num_t rand_reg(int lo, int hi);
        return reg_num_t'(lo + lcg_next() % (hi - lo + 1));
    endfunction

    function automatic logic [5:0] pick_funct(int unsigned sel);
        case (sel % 7)
            0: return FN_ADDU;
            1: return FN_SUBU;
            2: return FN_AND;
            3: return FN_OR;
            4: return FN_XOR;
            5: return FN_SLT;
            default: return FN_SLL;
        endcase
    endfunction

    function automatic logic [5:0] pick_imm_op(int unsigned sel);
        return (sel % 3 == 0) ? OP_ADDIU : ((sel % 3 == 1) ? OP_ORI : OP_LUI);
    endfunction

    function automatic word_t enc_r(logic [5:0] fn, reg_num_t rs, reg_num_t rt, reg_num_t rd,
                                    logic [4:0] shamt);
        return {OP_SPECIAL, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, reg_num_t rs, reg_num_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // past the end of the program the core reads SLL r0, r0, 0
    function automatic word_t read_program(word_t addr);
        word_t idx;
        idx = (addr - RESET_PC) >> 2;
        return (idx < prog_len) ? prog_mem[idx] : '0;
    endfunction

    task automatic emit(word_t w);
        prog_mem[prog_len] = w;
        prog_len = prog_len + 1;
    endtask

    task automatic build_program(int t);
        reg_num_t    p1;
        reg_num_t    p2;
        reg_num_t    rd;
        logic [5:0]  op;
        logic [15:0] imm;
        prog_len = '0;
        case (t)
            0: begin
                for (int r = 1; r <= 8; r++) begin
                    imm = 16'(lcg_next());
                    imm[15] = (r == 1) ? 1'b1 : ((r == 2) ? 1'b0 : imm[15]); // r1 < 0 < r2
                    emit(enc_i(OP_LUI, 0, reg_num_t'(r), imm));
                    emit(enc_i(OP_ORI, reg_num_t'(r), reg_num_t'(r), 16'(lcg_next())));
                end
                emit(enc_r(FN_SLT, 1, 2, 9, 0));
                emit(enc_r(FN_SLT, 2, 1, 10, 0));
                for (int k = 0; k < 14; k++) begin
                    emit(enc_r(pick_funct(k), rand_reg(1, 8), rand_reg(1, 8), rand_reg(9, 20),
                               5'(lcg_next())));
                end
            end
            1: begin
                emit(enc_i(OP_ADDIU, 0, 1, 16'h8001));
                emit(enc_i(OP_ORI, 0, 2, 16'hF00F));
                emit(enc_i(OP_LUI, 0, 3, 16'h8000));
                emit(enc_i(OP_ADDIU, 1, 4, 16'hFFFF));
                for (int k = 0; k < 20; k++) begin
                    emit(enc_i(pick_imm_op(lcg_next()), rand_reg(0, 7), rand_reg(1, 7),
                               16'(lcg_next())));
                end
            end
            2: begin
                emit(enc_i(OP_ADDIU, 0, 1, 16'h0005));
                emit(enc_i(OP_ADDIU, 0, 2, 16'hFFFD));
                p2 = 1;
                p1 = 2;
                for (int k = 0; k < 20; k++) begin
                    rd = rand_reg(1, 31); // reads the results one and two ahead
                    if (k % 4 == 3)
                        emit(enc_i(OP_ADDIU, p1, rd, 16'(lcg_next())));
                    else
                        emit(enc_r(pick_funct(lcg_next()), p1, p2, rd, 5'(lcg_next())));
                    p2 = p1;
                    p1 = rd;
                end
            end
            3: begin
                emit(enc_i(OP_ORI, 0, 5, 16'h00A5));
                emit(enc_i(OP_ADDIU, 5, 0, 16'h0123));
                emit(enc_r(FN_ADDU, 5, 5, 0, 0));
                emit(enc_r(6'h3f, 5, 5, 6, 0)); // funct outside the kept set
                emit(enc_r(FN_ADDU, 0, 5, 6, 0));
                emit(enc_r(FN_OR, 0, 0, 7, 0));
                for (int k = 0; k < 8; k++) begin
                    do op = 6'(lcg_next());
                    while (op == OP_SPECIAL || op == OP_ADDIU || op == OP_ORI || op == OP_LUI);
                    emit({op, 26'(lcg_next())});
                    emit(enc_r(FN_SUBU, 0, 5, reg_num_t'(9 + k), 0));
                end
            end
            default: begin
                for (int k = 0; k < 48; k++) begin
                    if (lcg_next() % 3 == 0)
                        emit(enc_i(pick_imm_op(lcg_next()), rand_reg(0, 31), rand_reg(1, 31),
                                   16'(lcg_next())));
                    else
                        emit(enc_r(pick_funct(lcg_next()), rand_reg(0, 31), rand_reg(0, 31),
                                   rand_reg(1, 31), 5'(lcg_next())));
                end
            end
        endcase
    endtask

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    // each request waits 0 to 3 extra cycles before data-ok
    always @(negedge Clk) begin
        if (!inst_req) begin
            inst_data_ok = 1'b0;
            delay_left   = -1;
        end else begin
            if (delay_left < 0)
                delay_left = int'(lcg_next() % 4);
            inst_data_ok = (delay_left == 0);
            if (delay_left == 0)
                inst_rdata = read_program(inst_addr);
            delay_left = delay_left - 1;
        end
    end

    always @(posedge Clk) begin
        cycle_count <= start_test ? 0 : cycle_count + 1;
        timed_out   <= !start_test && cycle_count >= cycle_limit;
    end

    initial begin
        wait (timed_out === 1'b1);
        $display("timeout: a test did not retire its writes within %0d cycles", cycle_limit);
        $display("Something failed");
        $finish;
    end

    mini_mips_core #(
        .RESET_PC(RESET_PC)
    ) i_mini_mips_core (
        .Clk                 (Clk),
        .Myreset             (Myreset),
        .inst_req_o          (inst_req),
        .inst_addr_o         (inst_addr),
        .inst_rdata_i        (inst_rdata),
        .inst_data_ok_i      (inst_data_ok),
        .debug_wb_pc_o       (trace_pc),
        .debug_wb_rf_wen_o   (trace_wen),
        .debug_wb_rf_wnum_o  (trace_wnum),
        .debug_wb_rf_wdata_o (trace_wdata)
    );

    tb_checker #(
        .RESET_PC(RESET_PC),
        .PROG_MAX(PROG_MAX)
    ) i_tb_checker (
        .Clk            (Clk),
        .start_i        (start_test),
        .end_i          (end_test),
        .prog_i         (prog_mem),
        .prog_len_i     (prog_len),
        .trace_pc_i     (trace_pc),
        .trace_wen_i    (trace_wen),
        .trace_wnum_i   (trace_wnum),
        .trace_wdata_i  (trace_wdata),
        .done_o         (test_done),
        .tests_failed_o (tests_failed),
        .errors_o       (errors),
        .checks_o       (checks)
    );

    initial begin
        Myreset      = 1'b1;
        inst_data_ok = 1'b0;
        inst_rdata   = '0;
        start_test   = 1'b0;
        end_test     = 1'b0;
        prog_len     = '0;
        cycle_limit  = 100;
        lcg_state    = 71813;
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge Clk);
            Myreset = 1'b1;
            @(negedge Clk); // the request line is low under reset, so no delay is drawn here
            build_program(t);
            cycle_limit = prog_len * 5 + 50;
            start_test  = 1'b1;
            repeat (2) @(negedge Clk);
            Myreset    = 1'b0;
            start_test = 1'b0;
            while (!test_done) @(posedge Clk);
            repeat (8) @(negedge Clk); // a stray write after the last expected one shows here
            end_test = 1'b1;
            @(negedge Clk);
            end_test = 1'b0;
        end
        $display("summary: %0d tests, %0d failed, %0d trace checks, %0d errors",
                 NUM_TESTS, tests_failed, checks, errors);
        if (tests_failed == 0 && errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`default_nettype none

module tb_checker
    import mips_isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'hBFC0_0000,
    parameter int    PROG_MAX = 64
) (
    input  wire              Clk,
    input  wire              start_i,
    input  wire              end_i,
    input  wire word_t       prog_i [PROG_MAX],
    input  wire logic [31:0] prog_len_i,
    input  wire word_t       trace_pc_i,
    input  wire logic [3:0]  trace_wen_i,
    input  wire reg_num_t    trace_wnum_i,
    input  wire word_t       trace_wdata_i,
    output logic             done_o,
    output int               tests_failed_o,
    output int               errors_o,
    output int               checks_o
);

    timeunit 1ns;
    timeprecision 1ps;

    word_t    exp_pc   [PROG_MAX];
    reg_num_t exp_num  [PROG_MAX];
    word_t    exp_data [PROG_MAX];
    int       exp_count = 0;
    int       exp_idx = 0;
    int       test_errors = 0;
    int       test_num = 0;
    logic     active = 1'b0;

    // runs the program on a register model and lists every write to a nonzero register
    function automatic int run_reference();
        word_t    regs [32];
        instr_u   ins;
        word_t    a;
        word_t    b;
        word_t    res;
        reg_num_t dst;
        logic     wr;
        int       n;
        n = 0;
        for (int r = 0; r < 32; r++)
            regs[r] = '0;
        for (int i = 0; i < int'(prog_len_i); i++) begin
            ins = prog_i[i];
            a   = regs[ins.r_fmt.rs];
            b   = regs[ins.r_fmt.rt];
            wr  = 1'b1;
            dst = ins.i_fmt.rt;
            res = '0;
            case (ins.r_fmt.opcode)
                OP_SPECIAL: begin
                    dst = ins.r_fmt.rd;
                    case (ins.r_fmt.funct)
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  res = b << ins.r_fmt.shamt;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + {{16{ins.i_fmt.imm16[15]}}, ins.i_fmt.imm16};
                OP_ORI:   res = a | {16'h0000, ins.i_fmt.imm16};
                OP_LUI:   res = {ins.i_fmt.imm16, 16'h0000};
                default:  wr = 1'b0; // unknown opcodes retire silently
            endcase
            if (wr && dst != '0) begin
                regs[dst]   = res;
                exp_pc[n]   = RESET_PC + word_t'(4 * i);
                exp_num[n]  = dst;
                exp_data[n] = res;
                n++;
            end
        end
        return n;
    endfunction

    function automatic string test_name(int n);
        case (n)
            1: return "r-type operations";
            2: return "immediate extension";
            3: return "dependent chains";
            4: return "register zero and unknown opcodes";
            default: return "random mix under memory latency";
        endcase
    endfunction

    task automatic flag_error(string msg);
        $display("ERROR %0t: %s", $time, msg);
        test_errors++;
        errors_o++;
    endtask

    initial begin
        tests_failed_o = 0;
        errors_o       = 0;
        checks_o       = 0;
    end

    assign done_o = active && (exp_idx == exp_count);

    always @(posedge Clk) begin
        if (start_i) begin
            if (!active) begin
                test_num++;
                test_errors = 0;
            end
            active    = 1'b1;
            exp_count = run_reference();
            exp_idx   = 0;
        end else if (end_i && active) begin
            active = 1'b0;
            if (test_errors != 0 || exp_idx != exp_count)
                tests_failed_o++;
            $display("test %0d %s: %0d of %0d writes traced, %0d errors, %s",
                     test_num, test_name(test_num), exp_idx, exp_count, test_errors,
                     (test_errors == 0 && exp_idx == exp_count) ? "passed" : "FAILED");
        end
    end

    // trace outputs change on the rising edge and are sampled mid-cycle
    always @(negedge Clk) begin
        if (active && trace_wen_i != 4'h0) begin
            checks_o++;
            if (trace_wen_i != 4'hf)
                flag_error($sformatf("wen is %h, expected all ones", trace_wen_i));
            if (exp_idx >= exp_count) begin
                flag_error($sformatf("unexpected write pc %h r%0d", trace_pc_i, trace_wnum_i));
            end else begin
                if (trace_pc_i != exp_pc[exp_idx] || trace_wnum_i != exp_num[exp_idx] ||
                    trace_wdata_i != exp_data[exp_idx])
                    flag_error($sformatf("got pc %h r%0d=%h, expected pc %h r%0d=%h",
                                         trace_pc_i, trace_wnum_i, trace_wdata_i,
                                         exp_pc[exp_idx], exp_num[exp_idx],
                                         exp_data[exp_idx]));
                exp_idx++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== mini_mips_core.sv ====
`default_nettype none

module mini_mips_core
    import pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  wire         Clk,
    input  wire         Myreset,
    output logic        inst_req_o,
    output word_t       inst_addr_o,
    input  wire word_t  inst_rdata_i,
    input  wire         inst_data_ok_i,
    output word_t       debug_wb_pc_o,
    output logic [3:0]  debug_wb_rf_wen_o,
    output reg_num_t    debug_wb_rf_wnum_o,
    output word_t       debug_wb_rf_wdata_o
);

    f_to_d_t   f_to_d;
    d_to_e_t   d_to_e;
    e_to_w_t   e_to_w;
    rf_write_t rf_write; // closes the loop from writeback into the register file

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) i_fetch_stage (
        .Clk            (Clk),
        .Myreset        (Myreset),
        .inst_data_ok_i (inst_data_ok_i),
        .inst_rdata_i   (inst_rdata_i),
        .inst_req_o     (inst_req_o),
        .inst_addr_o    (inst_addr_o),
        .f_to_d_o       (f_to_d)
    );

    decode_stage i_decode_stage (
        .Clk        (Clk),
        .Myreset    (Myreset),
        .f_to_d_i   (f_to_d),
        .rf_write_i (rf_write),
        .d_to_e_o   (d_to_e)
    );

    execute_stage i_execute_stage (
        .Clk      (Clk),
        .Myreset  (Myreset),
        .d_to_e_i (d_to_e),
        .e_to_w_o (e_to_w)
    );

    writeback_stage i_writeback_stage (
        .e_to_w_i            (e_to_w),
        .rf_write_o          (rf_write),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

endmodule

`default_nettype wire

// ==== writeback_stage.sv ====
`default_nettype none

module writeback_stage
    import pipe_pkg::*;
(
    input  wire e_to_w_t e_to_w_i,
    output rf_write_t    rf_write_o,
    output word_t        debug_wb_pc_o,
    output logic [3:0]   debug_wb_rf_wen_o,
    output reg_num_t     debug_wb_rf_wnum_o,
    output word_t        debug_wb_rf_wdata_o
);

    logic wr;

    assign wr = e_to_w_i.valid && e_to_w_i.wen && e_to_w_i.rd_num != '0; // r0 writes vanish

    assign rf_write_o.we   = wr;
    assign rf_write_o.num  = e_to_w_i.rd_num;
    assign rf_write_o.data = e_to_w_i.result;

    assign debug_wb_pc_o       = e_to_w_i.pc;
    assign debug_wb_rf_wen_o   = {4{wr}};
    assign debug_wb_rf_wnum_o  = e_to_w_i.rd_num;
    assign debug_wb_rf_wdata_o = e_to_w_i.result;

    // a retirement into register zero never reaches the trace
    always_comb begin
        a_no_r0_trace: assert final (debug_wb_rf_wen_o == '0 || debug_wb_rf_wnum_o != '0)
            else $error("trace reports a write to register zero");
    end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`default_nettype none

module execute_stage
    import mips_isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire          Clk,
    input  wire          Myreset,
    input  wire d_to_e_t d_to_e_i,
    output e_to_w_t      e_to_w_o
);

    e_to_w_t e_q;
    e_to_w_t e_next;
    word_t   src_a;
    word_t   src_b;
    word_t   op_b;

    // the instruction one ahead sits in e_q and has not reached the register file yet
    function automatic word_t forward(reg_num_t num, word_t val, e_to_w_t prev);
        if (prev.valid && prev.wen && prev.rd_num != '0 && prev.rd_num == num) begin
            return prev.result;
        end
        return val;
    endfunction

    assign src_a = forward(d_to_e_i.rs_num, d_to_e_i.rs_val, e_q);
    assign src_b = forward(d_to_e_i.rt_num, d_to_e_i.rt_val, e_q);
    assign op_b  = d_to_e_i.use_imm ? d_to_e_i.imm : src_b;

    always_comb begin
        e_next.valid  = d_to_e_i.valid;
        e_next.pc     = d_to_e_i.pc;
        e_next.rd_num = d_to_e_i.rd_num;
        e_next.wen    = d_to_e_i.wen;

        case (d_to_e_i.alu_op)
            ALU_ADD: e_next.result = src_a + op_b; // wraps, no overflow trap
            ALU_SUB: e_next.result = src_a - op_b;
            ALU_AND: e_next.result = src_a & op_b;
            ALU_OR:  e_next.result = src_a | op_b;
            ALU_XOR: e_next.result = src_a ^ op_b;
            ALU_SLT: e_next.result = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(op_b)};
            ALU_SLL: e_next.result = src_b << d_to_e_i.shamt;
            ALU_LUI: e_next.result = op_b;
            default: e_next.result = '0;
        endcase
    end

    always_ff @(posedge Clk) begin
        e_q <= e_next;
        if (Myreset) begin
            e_q.valid <= 1'b0;
        end
    end

    assign e_to_w_o = e_q;

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`default_nettype none

module decode_stage
    import mips_isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire            Clk,
    input  wire            Myreset,
    input  wire f_to_d_t   f_to_d_i,
    input  wire rf_write_t rf_write_i,
    output d_to_e_t        d_to_e_o
);

    instr_u  instr;
    word_t   rf_q [2**REG_W];
    word_t   rs_val;
    word_t   rt_val;
    d_to_e_t d_next;
    d_to_e_t d_q;

    // register zero reads zero, and a write in this same cycle is seen at once
    function automatic word_t read_reg(reg_num_t num, word_t stored, rf_write_t wr);
        if (num == '0) begin
            return '0;
        end
        if (wr.we && wr.num == num) begin
            return wr.data;
        end
        return stored;
    endfunction

    assign instr  = f_to_d_i.instr;
    assign rs_val = read_reg(instr.r_fmt.rs, rf_q[instr.r_fmt.rs], rf_write_i);
    assign rt_val = read_reg(instr.r_fmt.rt, rf_q[instr.r_fmt.rt], rf_write_i);

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            for (int i = 0; i < 2**REG_W; i++) begin
                rf_q[i] <= '0;
            end
        end else if (rf_write_i.we) begin
            rf_q[rf_write_i.num] <= rf_write_i.data;
        end
    end

    always_comb begin
        d_next.valid   = f_to_d_i.valid;
        d_next.pc      = f_to_d_i.pc;
        d_next.alu_op  = ALU_ADD;
        d_next.rs_num  = instr.r_fmt.rs;
        d_next.rs_val  = rs_val;
        d_next.rt_num  = instr.r_fmt.rt;
        d_next.rt_val  = rt_val;
        d_next.imm     = '0;
        d_next.use_imm = 1'b0;
        d_next.shamt   = instr.r_fmt.shamt;
        d_next.rd_num  = instr.r_fmt.rd;
        d_next.wen     = 1'b0; // unknown encodings retire without a write

        case (instr.r_fmt.opcode)
            OP_SPECIAL: begin
                d_next.wen = 1'b1;
                case (instr.r_fmt.funct)
                    FN_ADDU: d_next.alu_op = ALU_ADD;
                    FN_SUBU: d_next.alu_op = ALU_SUB;
                    FN_AND:  d_next.alu_op = ALU_AND;
                    FN_OR:   d_next.alu_op = ALU_OR;
                    FN_XOR:  d_next.alu_op = ALU_XOR;
                    FN_SLT:  d_next.alu_op = ALU_SLT;
                    FN_SLL:  d_next.alu_op = ALU_SLL;
                    default: d_next.wen    = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                d_next.alu_op  = ALU_ADD;
                d_next.use_imm = 1'b1;
                d_next.rd_num  = instr.i_fmt.rt;
                d_next.wen     = 1'b1;
                d_next.imm     = {{(XLEN-16){instr.i_fmt.imm16[15]}}, instr.i_fmt.imm16};
            end
            OP_ORI: begin
                d_next.alu_op  = ALU_OR;
                d_next.use_imm = 1'b1;
                d_next.rd_num  = instr.i_fmt.rt;
                d_next.wen     = 1'b1;
                d_next.imm     = {{(XLEN-16){1'b0}}, instr.i_fmt.imm16};
            end
            OP_LUI: begin
                d_next.alu_op  = ALU_LUI;
                d_next.use_imm = 1'b1;
                d_next.rd_num  = instr.i_fmt.rt;
                d_next.wen     = 1'b1;
                d_next.imm     = {instr.i_fmt.imm16, {(XLEN-16){1'b0}}};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        d_q <= d_next;
        if (Myreset) begin
            d_q.valid <= 1'b0;
        end
    end

    assign d_to_e_o = d_q;

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
`default_nettype none

module fetch_stage
    import pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  wire          Clk,
    input  wire          Myreset,
    input  wire          inst_data_ok_i,
    input  wire word_t   inst_rdata_i,
    output logic         inst_req_o,
    output word_t        inst_addr_o,
    output f_to_d_t      f_to_d_o
);

    logic    req_q;
    word_t   pc_q;
    f_to_d_t f_q;
    logic    fire;

    assign fire = req_q & inst_data_ok_i; // the request completes at this edge

    // req_q stays low for the first cycle out of reset, then a request is always open
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            req_q <= 1'b0;
            pc_q  <= RESET_PC;
        end else begin
            req_q <= 1'b1;
            if (fire) begin
                pc_q <= pc_q + word_t'(4);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (fire) begin
            f_q.pc    <= pc_q;
            f_q.instr <= inst_rdata_i;
        end
        f_q.valid <= fire; // one slot per returned word, bubble otherwise
        if (Myreset) begin
            f_q.valid <= 1'b0;
        end
    end

    assign inst_req_o  = req_q;
    assign inst_addr_o = pc_q;
    assign f_to_d_o    = f_q;

    // a waiting request keeps its address until the memory answers
    a_addr_stable: assert property (
        @(posedge Clk) disable iff (Myreset)
        (inst_req_o && !inst_data_ok_i) |=> (inst_req_o && $stable(inst_addr_o))
    ) else $error("instruction address moved while a request was pending");

endmodule

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    import mips_isa_pkg::*;

    localparam int XLEN  = 32; // data and address width
    localparam int REG_W = 5;

    typedef logic [REG_W-1:0] reg_num_t;
    typedef logic [XLEN-1:0]  word_t;

    // fetch to decode
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } f_to_d_t;

    // decode to execute, operands as read from the register file
    typedef struct packed {
        logic                      valid;
        word_t                     pc;
        alu_op_e                   alu_op;
        reg_num_t                  rs_num;
        word_t                     rs_val;
        reg_num_t                  rt_num;
        word_t                     rt_val;
        word_t                     imm;     // already extended or shifted
        logic                      use_imm; // second operand is imm instead of rt
        logic [$clog2(XLEN)-1:0]   shamt;
        reg_num_t                  rd_num;
        logic                      wen;
    } d_to_e_t;

    // execute to writeback
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_num_t rd_num;
        logic     wen;
        word_t    result;
    } e_to_w_t;

    // writeback back into the decode register file
    typedef struct packed {
        logic     we;
        reg_num_t num;
        word_t    data;
    } rf_write_t;

endpackage

`default_nettype wire

// ==== mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    // major opcodes in bits 31:26
    localparam logic [5:0] OP_SPECIAL = 6'h00; // R-type, operation selected by funct
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // funct codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt; // destination for the I-type set kept here
        logic [15:0] imm16;
    } i_fmt_t;

    // one fetched word, seen either as register or as immediate format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI // passes the already shifted immediate through
    } alu_op_e;

endpackage

`default_nettype wire
